/* verilog/fetch_pkg.sv */
// Shared definitions for the instruction fetch stage and its ROM.
// Every RTL file imports this package, so it is compiled first.

package fetch_pkg;

	// datapath and memory geometry
	localparam int unsigned XLEN = 32;
	localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;
	localparam int unsigned ROM_WORDS = 64;
	localparam int unsigned ROM_AW = 6;

	// major opcodes of the supported RV32I subset
	typedef enum logic [6:0] {
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		BRANCH = 7'b1100011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011,
		SYSTEM = 7'b1110011
	} opcode_e;

	// read response codes, as on AXI
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} resp_e;

	typedef enum logic [1:0] {
		ADDR,
		DATA,
		ISSUE,
		WAIT_COMMIT
	} fetch_state_e;

	// redirect request, sampled at commit
	typedef struct packed {
		logic trap;
		logic [XLEN-1:0] trap_target;
		logic jump;
		logic [XLEN-1:0] jump_target;
		logic branch;
		logic [XLEN-1:0] branch_target;
	} redirect_t;

	// instruction handed to decode
	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] inst;
		logic illegal;
		logic fault;
	} fetch_t;

	typedef struct packed {
		logic [XLEN-1:0] addr;
	} rd_req_t;

	typedef struct packed {
		logic [XLEN-1:0] data;
		resp_e resp;
	} rd_rsp_t;

endpackage

/* verilog/pc_counter.sv */
// Program counter register of the fetch stage.
// Loads the next address when advance_i pulses, picking a redirect target
// by priority or falling back to the sequential address.

`timescale 1ns/1ps

module pc_counter (
	input  logic clock,
	input  logic reset,
	input  logic advance_i,
	input  fetch_pkg::redirect_t redirect_i,
	output logic [fetch_pkg::XLEN-1:0] pc_o
);

	import fetch_pkg::*;

	logic [XLEN-1:0] pc_q;
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] pc_next;

	assign pc_plus4 = pc_q + XLEN'(4);

	// trap or mret wins over jumps, jumps over taken branches
	always_comb begin
		if (redirect_i.trap) begin
			pc_next = redirect_i.trap_target;
		end else if (redirect_i.jump) begin
			pc_next = redirect_i.jump_target;
		end else if (redirect_i.branch) begin
			pc_next = redirect_i.branch_target;
		end else begin
			pc_next = pc_plus4;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pc_q <= RESET_PC;
		end else if (advance_i) begin
			pc_q <= pc_next;
		end
	end

	assign pc_o = pc_q;

endmodule

/* verilog/inst_checker.sv */
// Legality check for one 32-bit instruction word.
// Purely combinational; flags anything outside the supported RV32I subset,
// including the few SYSTEM encodings the core handles.

`timescale 1ns/1ps

module inst_checker (
	input  logic [fetch_pkg::XLEN-1:0] inst_i,
	output logic illegal_o
);

	import fetch_pkg::*;

	// exact SYSTEM words
	localparam logic [XLEN-1:0] ECALL_WORD = 32'h0000_0073;
	localparam logic [XLEN-1:0] EBREAK_WORD = 32'h0010_0073;
	localparam logic [XLEN-1:0] MRET_WORD = 32'h3020_0073;

	opcode_e opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic legal;

	assign opcode = opcode_e'(inst_i[6:0]);
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	always_comb begin
		legal = 1'b0;
		case (opcode)
			LUI, AUIPC, JAL: begin
				legal = 1'b1;
			end
			JALR: begin
				legal = (funct3 == 3'd0);
			end
			// funct3 2 and 3 are unused branch encodings
			BRANCH: begin
				legal = (funct3 != 3'd2) && (funct3 != 3'd3);
			end
			// lb lh lw lbu lhu
			LOAD: begin
				legal = (funct3 <= 3'd2) || (funct3 == 3'd4) || (funct3 == 3'd5);
			end
			STORE: begin
				legal = (funct3 <= 3'd2);
			end
			OP_IMM: begin
				if (funct3 == 3'd1) begin
					legal = (funct7 == 7'b0000000);
				end else if (funct3 == 3'd5) begin
					// srli or srai
					legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
				end else begin
					legal = 1'b1;
				end
			end
			OP: begin
				legal = 1'b1;
			end
			SYSTEM: begin
				// csrrw and csrrs only, plus the three fixed words
				legal = (inst_i == ECALL_WORD) || (inst_i == EBREAK_WORD) ||
					(inst_i == MRET_WORD) || (funct3 == 3'd1) || (funct3 == 3'd2);
			end
			default: begin
				legal = 1'b0;
			end
		endcase
	end

	assign illegal_o = ~legal;

endmodule

/* verilog/fetch_unit.sv */
// Fetch state machine of the multi-cycle core.
// Requests one word at the current pc over the read-address channel,
// takes the answer from the read-data channel, hands it to decode with a
// one-cycle valid pulse and then waits for commit before the next fetch.

`timescale 1ns/1ps

module fetch_unit (
	input  logic clock,
	input  logic reset,
	input  logic commit_i,
	input  fetch_pkg::redirect_t redirect_i,
	output logic ar_valid_o,
	input  logic ar_ready_i,
	output fetch_pkg::rd_req_t ar_o,
	input  logic r_valid_i,
	output logic r_ready_o,
	input  fetch_pkg::rd_rsp_t r_i,
	output logic fetch_valid_o,
	output fetch_pkg::fetch_t fetch_o
);

	import fetch_pkg::*;

	fetch_state_e state_q;
	fetch_state_e state_d;

	logic [XLEN-1:0] pc;
	logic ar_hs;
	logic r_hs;
	logic advance;
	logic resp_ok;
	logic word_illegal;

	assign ar_hs = ar_valid_o & ar_ready_i;
	assign r_hs = r_valid_i & r_ready_o;
	assign advance = (state_q == WAIT_COMMIT) & commit_i;
	assign resp_ok = (r_i.resp == OKAY);

	pc_counter u_pc (
		.clock      (clock),
		.reset      (reset),
		.advance_i  (advance),
		.redirect_i (redirect_i),
		.pc_o       (pc)
	);

	inst_checker u_checker (
		.inst_i    (r_i.data),
		.illegal_o (word_illegal)
	);

	always_comb begin
		state_d = state_q;
		case (state_q)
			ADDR: begin
				if (ar_hs) begin
					state_d = DATA;
				end
			end
			DATA: begin
				if (r_hs) begin
					state_d = ISSUE;
				end
			end
			// the valid pulse lasts exactly this one state
			ISSUE: begin
				state_d = WAIT_COMMIT;
			end
			WAIT_COMMIT: begin
				if (commit_i) begin
					state_d = ADDR;
				end
			end
			default: begin
				state_d = ADDR;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= ADDR;
		end else begin
			state_q <= state_d;
		end
	end

	// pc only moves at commit, so the address is stable while ADDR waits
	assign ar_valid_o = (state_q == ADDR);
	assign ar_o.addr = pc;
	assign r_ready_o = (state_q == DATA);
	assign fetch_valid_o = (state_q == ISSUE);

	// error response becomes an access fault with a zero word
	always_ff @(posedge clock) begin
		if (r_hs) begin
			fetch_o.pc <= pc;
			fetch_o.inst <= resp_ok ? r_i.data : '0;
			fetch_o.illegal <= resp_ok & word_illegal;
			fetch_o.fault <= ~resp_ok;
		end
	end

endmodule

/* verilog/inst_rom.sv */
// Small on-chip instruction memory with a read slave interface.
// Filled through the load port while reset is held. Each accepted address
// is answered after 0 to 3 cycles chosen by a 4-bit LFSR; addresses
// outside the array get SLVERR with zero data.

`timescale 1ns/1ps

module inst_rom (
	input  logic clock,
	input  logic reset,
	input  logic load_en_i,
	input  logic [fetch_pkg::ROM_AW-1:0] load_addr_i,
	input  logic [fetch_pkg::XLEN-1:0] load_data_i,
	input  logic ar_valid_i,
	output logic ar_ready_o,
	input  fetch_pkg::rd_req_t ar_i,
	output logic r_valid_o,
	input  logic r_ready_i,
	output fetch_pkg::rd_rsp_t r_o
);

	import fetch_pkg::*;

	logic [XLEN-1:0] mem [ROM_WORDS];

	logic busy;
	logic r_valid_q;
	logic [1:0] wait_q;
	logic [3:0] lfsr;
	logic accept;
	logic [XLEN-1:0] offset;
	logic [ROM_AW-1:0] word_idx;
	logic in_range;

	always_ff @(posedge clock) begin
		if (load_en_i) begin
			mem[load_addr_i] <= load_data_i;
		end
	end

	// word index relative to the reset vector
	assign offset = ar_i.addr - RESET_PC;
	assign word_idx = offset[ROM_AW+1:2];
	assign in_range = (offset[XLEN-1:ROM_AW+2] == '0);

	assign ar_ready_o = ~busy;
	assign accept = ar_valid_i & ~busy;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			r_valid_q <= 1'b0;
			wait_q <= 2'd0;
			lfsr <= 4'b0001;
		end else if (accept) begin
			busy <= 1'b1;
			wait_q <= lfsr[1:0];
			r_valid_q <= (lfsr[1:0] == 2'd0);
			// x^4 + x^3 + 1
			lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};
		end else if (r_valid_q) begin
			if (r_ready_i) begin
				r_valid_q <= 1'b0;
				busy <= 1'b0;
			end
		end else if (busy) begin
			wait_q <= wait_q - 2'd1;
			r_valid_q <= (wait_q == 2'd1);
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			r_o.data <= in_range ? mem[word_idx] : '0;
			r_o.resp <= in_range ? OKAY : SLVERR;
		end
	end

	assign r_valid_o = r_valid_q;

endmodule

/* verilog/fetch_top.sv */
// Fetch stage top level: the fetch unit wired to its instruction ROM.
// The core drives commit and redirect; the ROM is loaded during reset.

`timescale 1ns/1ps

module fetch_top (
	input  logic clock,
	input  logic reset,
	input  logic load_en_i,
	input  logic [fetch_pkg::ROM_AW-1:0] load_addr_i,
	input  logic [fetch_pkg::XLEN-1:0] load_data_i,
	input  logic commit_i,
	input  fetch_pkg::redirect_t redirect_i,
	output logic fetch_valid_o,
	output fetch_pkg::fetch_t fetch_o
);

	import fetch_pkg::*;

	// read-address and read-data channels
	logic ar_valid;
	logic ar_ready;
	rd_req_t ar;
	logic r_valid;
	logic r_ready;
	rd_rsp_t r;

	fetch_unit u_fetch (
		.clock         (clock),
		.reset         (reset),
		.commit_i      (commit_i),
		.redirect_i    (redirect_i),
		.ar_valid_o    (ar_valid),
		.ar_ready_i    (ar_ready),
		.ar_o          (ar),
		.r_valid_i     (r_valid),
		.r_ready_o     (r_ready),
		.r_i           (r),
		.fetch_valid_o (fetch_valid_o),
		.fetch_o       (fetch_o)
	);

	inst_rom u_rom (
		.clock       (clock),
		.reset       (reset),
		.load_en_i   (load_en_i),
		.load_addr_i (load_addr_i),
		.load_data_i (load_data_i),
		.ar_valid_i  (ar_valid),
		.ar_ready_o  (ar_ready),
		.ar_i        (ar),
		.r_valid_o   (r_valid),
		.r_ready_i   (r_ready),
		.r_o         (r)
	);

endmodule

/* verification/fetch_sva.sv */
// Handshake and pulse checks for the fetch unit.
// Attached to every fetch_unit instance by the bind at the end of the file.

`timescale 1ns/1ps

module fetch_sva (
	input logic clock,
	input logic reset,
	input logic commit_i,
	input logic ar_valid_i,
	input logic ar_ready_i,
	input fetch_pkg::rd_req_t ar_i,
	input logic fetch_valid_i
);

	// set by the valid pulse, cleared by the commit that follows it
	logic awaiting_commit;

	always_ff @(posedge clock) begin
		if (reset) begin
			awaiting_commit <= 1'b0;
		end else if (fetch_valid_i) begin
			awaiting_commit <= 1'b1;
		end else if (commit_i) begin
			awaiting_commit <= 1'b0;
		end
	end

	a_single_pulse: assert property (@(posedge clock) disable iff (reset)
		fetch_valid_i |=> !fetch_valid_i)
		else $error("fetch_valid_o stayed high for two cycles");

	a_ar_hold: assert property (@(posedge clock) disable iff (reset)
		ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
		else $error("read address dropped or changed before ar_ready");

	a_no_early_request: assert property (@(posedge clock) disable iff (reset)
		awaiting_commit |-> !ar_valid_i)
		else $error("read address raised before commit");

endmodule

bind fetch_unit fetch_sva u_sva (
	.clock         (clock),
	.reset         (reset),
	.commit_i      (commit_i),
	.ar_valid_i    (ar_valid_o),
	.ar_ready_i    (ar_ready_i),
	.ar_i          (ar_o),
	.fetch_valid_i (fetch_valid_o)
);

/* verification/fetch_tb.sv */
// Testbench for the fetch stage top level.
// Loads a short program image during reset, then walks a table of commit
// redirects with random commit delays and checks every fetched word.

`timescale 1ns/1ps

module fetch_tb;

	import fetch_pkg::*;

	localparam int IMAGE_WORDS = 8;
	localparam int IMAGE_AW = 3;
	localparam int NUM_STEPS = 12;
	localparam int STEP_AW = 4;
	localparam int WATCHDOG_CYCLES = (NUM_STEPS + 1) * 20 + 16;

	logic clock;
	logic reset;
	logic load_en;
	logic [ROM_AW-1:0] load_addr;
	logic [XLEN-1:0] load_data;
	logic commit;
	redirect_t redirect;
	logic fetch_valid;
	fetch_t fetch;

	int pulse_count;
	logic [31:0] lfsr_state;

	// lui, ecall, srai, slli with bad funct7, system funct3 0, mret,
	// branch funct3 2, load funct3 3
	logic [XLEN-1:0] image_word [IMAGE_WORDS] = '{
		32'h0000_0537, 32'h0000_0073, 32'h4010_5093, 32'h4010_1093,
		32'h0020_0073, 32'h3020_0073, 32'h0000_2063, 32'h0000_3003
	};
	logic image_illegal [IMAGE_WORDS] = '{
		1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1
	};

	string step_name [NUM_STEPS] = '{
		"seq_1", "seq_2", "seq_3", "jump_over_branch", "trap_over_all", "seq_4",
		"branch_out_of_rom", "jump_below_rom", "trap_back", "branch_to_start",
		"jump_over_branch_2", "seq_5"
	};
	// flag and target pairs in trap jump branch order
	redirect_t step_redirect [NUM_STEPS] = '{
		{1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 32'h0},
		{1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 32'h0},
		{1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 32'h0},
		{1'b0, 32'h0, 1'b1, 32'h8000_0014, 1'b1, 32'h8000_0000},
		{1'b1, 32'h8000_0018, 1'b1, 32'h8000_0004, 1'b1, 32'h8000_0008},
		{1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 32'h0},
		{1'b0, 32'h0, 1'b0, 32'h0, 1'b1, 32'h8000_0100},
		{1'b0, 32'h0, 1'b1, 32'h0000_1000, 1'b0, 32'h0},
		{1'b1, 32'h8000_0008, 1'b0, 32'h0, 1'b1, 32'h8000_0100},
		{1'b0, 32'h0, 1'b0, 32'h0, 1'b1, 32'h8000_0000},
		{1'b0, 32'h0, 1'b1, 32'h8000_000c, 1'b1, 32'h8000_0010},
		{1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 32'h0}
	};
	// pc of the fetch after each commit
	logic [XLEN-1:0] step_pc [NUM_STEPS] = '{
		32'h8000_0004, 32'h8000_0008, 32'h8000_000c, 32'h8000_0014,
		32'h8000_0018, 32'h8000_001c, 32'h8000_0100, 32'h0000_1000,
		32'h8000_0008, 32'h8000_0000, 32'h8000_000c, 32'h8000_0010
	};

	fetch_top u_dut (
		.clock         (clock),
		.reset         (reset),
		.load_en_i     (load_en),
		.load_addr_i   (load_addr),
		.load_data_i   (load_data),
		.commit_i      (commit),
		.redirect_i    (redirect),
		.fetch_valid_o (fetch_valid),
		.fetch_o       (fetch)
	);

	always #4 clock = ~clock;

	always @(negedge clock) begin
		if (fetch_valid === 1'b1) begin
			pulse_count <= pulse_count + 1;
		end
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_fetch(input string name, input fetch_t exp, input fetch_t act);
		string msg;
		if (act !== exp) begin
			msg = $sformatf("Mismatch %s: expected pc %h inst %h illegal %b fault %b",
				name, exp.pc, exp.inst, exp.illegal, exp.fault);
			msg = {msg, $sformatf(", actual pc %h inst %h illegal %b fault %b",
				act.pc, act.inst, act.illegal, act.fault)};
			fail_run(msg);
		end
	endtask

	task automatic check_pc(input string name, input logic [XLEN-1:0] exp,
			input logic [XLEN-1:0] act);
		if (act !== exp) begin
			fail_run($sformatf("Mismatch %s: expected pc %h, actual pc %h", name, exp, act));
		end
	endtask

	task automatic check_valid(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			fail_run($sformatf("Mismatch %s: expected fetch_valid %b, actual %b",
				name, exp, act));
		end
	endtask

	// galois LFSR stepped once per random bit
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic random_bits(input int n, output logic [3:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[2:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	// trap or mret first, then jump, then taken branch, else pc + 4
	function automatic logic [XLEN-1:0] priority_pc(input logic [XLEN-1:0] cur,
			input redirect_t r);
		if (r.trap) begin
			return r.trap_target;
		end else if (r.jump) begin
			return r.jump_target;
		end else if (r.branch) begin
			return r.branch_target;
		end
		return cur + 32'd4;
	endfunction

	function automatic fetch_t expect_fetch(input logic [XLEN-1:0] pc);
		logic [XLEN-1:0] offset;
		fetch_t f;
		offset = pc - RESET_PC;
		f.pc = pc;
		if (offset >= ROM_WORDS * 4) begin
			f.inst = '0;
			f.illegal = 1'b0;
			f.fault = 1'b1;
		end else begin
			f.inst = image_word[offset[IMAGE_AW+1:2]];
			f.illegal = image_illegal[offset[IMAGE_AW+1:2]];
			f.fault = 1'b0;
		end
		return f;
	endfunction

	task automatic wait_fetch(input string name, input logic [XLEN-1:0] pc);
		while (fetch_valid !== 1'b1) begin
			@(negedge clock);
		end
		check_pc(name, pc, fetch.pc);
		check_fetch(name, expect_fetch(pc), fetch);
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		fail_run("watchdog expired before all fetches were seen");
	end

	initial begin
		int n;
		logic [XLEN-1:0] model_pc;
		logic [3:0] delay;
		clock = 1'b1;
		reset = 1'b1;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		commit = 1'b0;
		redirect = '0;
		pulse_count = 0;
		lfsr_state = 32'hbd22_0953;

		// ROM image goes in while reset is held
		for (n = 0; n < IMAGE_WORDS; n++) begin
			@(negedge clock);
			if (n > 0) begin
				check_valid("reset", 1'b0, fetch_valid);
			end
			load_en = 1'b1;
			load_addr = ROM_AW'(n);
			load_data = image_word[IMAGE_AW'(n)];
		end
		@(negedge clock);
		load_en = 1'b0;
		reset = 1'b0;

		model_pc = RESET_PC;
		wait_fetch("first_fetch", model_pc);
		for (n = 0; n < NUM_STEPS; n++) begin
			random_bits(2, delay);
			// the unit only takes commit once it sits in WAIT_COMMIT
			@(negedge clock);
			repeat (delay) @(negedge clock);
			commit = 1'b1;
			redirect = step_redirect[STEP_AW'(n)];
			model_pc = priority_pc(model_pc, step_redirect[STEP_AW'(n)]);
			if (model_pc !== step_pc[STEP_AW'(n)]) begin
				fail_run($sformatf("step table and reference model disagree at %s",
					step_name[STEP_AW'(n)]));
			end
			@(negedge clock);
			commit = 1'b0;
			redirect = '0;
			wait_fetch(step_name[STEP_AW'(n)], model_pc);
		end

		// no further pulse may come without a commit
		repeat (6) @(negedge clock);
		if (pulse_count != NUM_STEPS + 1) begin
			fail_run($sformatf("Mismatch pulse_count: expected %0d, actual %0d",
				NUM_STEPS + 1, pulse_count));
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

/* compile.f */
verilog/fetch_pkg.sv
verilog/pc_counter.sv
verilog/inst_checker.sv
verilog/fetch_unit.sv
verilog/inst_rom.sv
verilog/fetch_top.sv
verification/fetch_sva.sv
verification/fetch_tb.sv

/* Makefile */
# Verilator build and run for the fetch stage testbench.
# The simulator's exit status is the test result.

SRCS := $(shell grep -v '^+' compile.f)

all: run

obj_dir/Vfetch_tb: compile.f $(SRCS)
	verilator --binary --timing --assert --top-module fetch_tb -f compile.f -Mdir obj_dir

run: obj_dir/Vfetch_tb
	./obj_dir/Vfetch_tb

clean:
	rm -rf obj_dir

.PHONY: all run clean
